// ==== Makefile ====
TOP = cacheTb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+source
source/cachePkg.sv
source/busPkg.sv
source/tagStore.sv
source/lruTracker.sv
source/dataStore.sv
source/cacheControl.sv
source/setAssocCache.sv
tests/memoryModel.sv
tests/cache_assertions.sv
tests/cacheTb.sv

// ==== source/busPkg.sv ====
`include "cache_macros.svh"

package busPkg;

  typedef logic [`DATA_W-1:0]   wordT;
  typedef logic [`DATA_W/8-1:0] byteEnT;

  typedef enum logic {
    CPU_READ,
    CPU_WRITE
  } cpuOpE;

  typedef struct packed {
    logic               valid;
    cpuOpE              op;
    logic [`ADDR_W-1:0] addr;
    wordT               wdata;
    byteEnT             byteEn;
  } cpuReqT;

  typedef struct packed {
    logic ok;
    logic miss;
    wordT rdata;
  } cpuRespT;

  typedef struct packed {
    logic               valid;
    logic               write;
    logic [`ADDR_W-1:0] addr;  // line aligned
    wordT               wdata;
  } memReqT;

  typedef struct packed {
    logic addrOk;
    logic dataOk;
    logic last;
    wordT rdata;
  } memRespT;

endpackage

// ==== source/cacheControl.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module cacheControl (
  input  logic                   clk,
  input  logic                   rst,
  input  busPkg::cpuReqT         cpuReq,
  output busPkg::cpuRespT        cpuResp,
  output busPkg::memReqT         memReq,
  input  busPkg::memRespT        memResp,
  output cachePkg::addrFieldsT   fields,
  output cachePkg::wayIdxT       selWay,
  input  logic [`CACHE_WAYS-1:0] hitVec,
  input  logic [`CACHE_WAYS-1:0] validVec,
  input  cachePkg::tagT          selTag,
  input  logic                   selDirty,
  input  cachePkg::wayIdxT       victimWay,
  output logic                   install,
  output logic                   markDirty,
  output logic                   dirtyIn,
  output logic                   touch,
  output cachePkg::wordIdxT      word,
  output logic                   wrEn,
  output busPkg::byteEnT         byteEn,
  output busPkg::wordT           wrData,
  input  busPkg::wordT           rdData
);
  import cachePkg::*;
  import busPkg::*;

  cacheStateE state;
  cacheStateE nextState;
  wayIdxT     chosenWay;   // held from LOOKUP to FINISH
  wayIdxT     hitWay;
  wordIdxT    beatCnt;
  addrFieldsT lineAddr;
  logic       hit;
  logic       isWrite;
  logic       inBurst;
  logic       lastBeat;
  logic       lastSeen;

  assign fields   = addrFieldsT'(cpuReq.addr);
  assign isWrite  = (cpuReq.op == CPU_WRITE);
  assign hit      = |hitVec;
  assign inBurst  = (state == WRITEBACK) || (state == REFILL);
  assign lastBeat = memResp.dataOk && memResp.last;

  always_comb begin
    hitWay = '0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (hitVec[w]) hitWay = wayIdxT'(w);
    end
  end

  assign selWay = (state == LOOKUP) ? (hit ? hitWay : victimWay) : chosenWay;

  ////////////////////////////////////////////////////////////////////////////
  // state and beat counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= IDLE;
      chosenWay <= '0;
      beatCnt   <= '0;
      lastSeen  <= 1'b0;
    end else begin
      state    <= nextState;
      lastSeen <= inBurst && lastBeat;   // forces a gap between bursts
      if (state == LOOKUP) chosenWay <= selWay;
      if (!inBurst || lastBeat) begin
        beatCnt <= '0;
      end else if (memResp.dataOk) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE:      if (cpuReq.valid) nextState = LOOKUP;
      LOOKUP: begin
        if (hit) nextState = IDLE;
        else if (selDirty && validVec[victimWay]) nextState = WRITEBACK;
        else nextState = REFILL;
      end
      WRITEBACK: if (lastBeat) nextState = REFILL;
      REFILL:    if (lastBeat) nextState = FINISH;
      FINISH:    nextState = IDLE;
      default:   nextState = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus and store control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    lineAddr        = fields;
    lineAddr.word   = '0;
    lineAddr.offset = '0;
    if (state == WRITEBACK) lineAddr.tag = selTag;   // victim's own address
  end

  always_comb begin
    cpuResp.ok    = 1'b0;
    cpuResp.miss  = 1'b0;
    cpuResp.rdata = rdData;
    memReq.valid  = inBurst && !lastSeen;
    memReq.write  = (state == WRITEBACK);
    memReq.addr   = lineAddr;
    memReq.wdata  = rdData;
    install       = 1'b0;
    markDirty     = 1'b0;
    dirtyIn       = isWrite;
    touch         = 1'b0;
    word          = inBurst ? beatCnt : fields.word;
    wrEn          = 1'b0;
    byteEn        = cpuReq.byteEn;
    wrData        = cpuReq.wdata;
    case (state)
      LOOKUP: begin
        cpuResp.miss = !hit;
        if (hit) begin
          cpuResp.ok = 1'b1;
          touch      = 1'b1;
          wrEn       = isWrite;
          markDirty  = isWrite;
        end
      end
      REFILL: begin
        wrEn   = memResp.dataOk;
        byteEn = '1;
        wrData = memResp.rdata;
      end
      FINISH: begin
        cpuResp.ok = 1'b1;
        touch      = 1'b1;
        install    = 1'b1;
        wrEn       = isWrite;   // merge cpu bytes over refilled word
      end
      default: ;
    endcase
  end

endmodule

// ==== source/cachePkg.sv ====
`include "cache_macros.svh"

package cachePkg;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,      // dirty victim out to memory
    REFILL,         // new line in from memory
    FINISH
  } cacheStateE;

  typedef logic [`WAY_W-1:0]  wayIdxT;
  typedef logic [`SET_W-1:0]  setIdxT;
  typedef logic [`WORD_W-1:0] wordIdxT;
  typedef logic [`TAG_W-1:0]  tagT;

  // 0 is most recently used
  typedef logic [1:0] lruAgeT;

  // overlays a cpu byte address, msb first
  typedef struct packed {
    tagT                tag;
    setIdxT             set;
    wordIdxT            word;
    logic [`BYTE_W-1:0] offset;
  } addrFieldsT;

endpackage

// ==== source/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// geometry
`define CACHE_WAYS 4
`define CACHE_SETS 16
`define LINE_WORDS 4

// bus widths
`define ADDR_W 32
`define DATA_W 32

// derived field widths
`define WAY_W  $clog2(`CACHE_WAYS)
`define SET_W  $clog2(`CACHE_SETS)
`define WORD_W $clog2(`LINE_WORDS)
`define BYTE_W $clog2(`DATA_W / 8)

// tag is what is left above set, word and byte offset
`define TAG_W  (`ADDR_W - `SET_W - `WORD_W - `BYTE_W)

`endif

// ==== source/dataStore.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module dataStore (
  input  logic              clk,
  input  cachePkg::setIdxT  set,
  input  cachePkg::wayIdxT  way,
  input  cachePkg::wordIdxT word,
  input  logic              wrEn,
  input  busPkg::byteEnT    byteEn,
  input  busPkg::wordT      wrData,
  output busPkg::wordT      rdData
);
  import busPkg::*;

  localparam int ROWS = `CACHE_SETS * `LINE_WORDS;

  // one array per way, row is {set, word}
  wordT                           words [`CACHE_WAYS][ROWS];
  logic [`SET_W+`WORD_W-1:0]      rowIdx;

  assign rowIdx = {set, word};

  ////////////////////////////////////////////////////////////////////////////
  // byte-enabled write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wrEn) begin
      for (int b = 0; b < `DATA_W / 8; b++) begin
        if (byteEn[b]) begin
          words[way][rowIdx][8*b +: 8] <= wrData[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read, no extra cycle
  ////////////////////////////////////////////////////////////////////////////

  assign rdData = words[way][rowIdx];

endmodule

// ==== source/lruTracker.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module lruTracker (
  input  logic                   clk,
  input  logic                   rst,
  input  cachePkg::setIdxT       set,
  input  logic [`CACHE_WAYS-1:0] validVec,
  input  logic                   touch,
  input  cachePkg::wayIdxT       touchWay,
  output cachePkg::wayIdxT       victimWay
);
  import cachePkg::*;

  lruAgeT ages [`CACHE_SETS][`CACHE_WAYS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          ages[s][w] <= '0;
        end
      end
    end else if (touch) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (wayIdxT'(w) == touchWay) begin
          ages[set][w] <= '0;
        end else if (ages[set][w] <= ages[set][touchWay]) begin
          ages[set][w] <= ages[set][w] + 1'b1;   // younger ways age by one
        end
      end
    end
  end

  // first invalid way, else oldest with low index winning ties
  always_comb begin
    logic found;
    found     = 1'b0;
    victimWay = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!found && !validVec[w]) begin
        victimWay = wayIdxT'(w);
        found     = 1'b1;
      end
    end
    if (!found) begin
      for (int w = 1; w < `CACHE_WAYS; w++) begin
        if (ages[set][w] > ages[set][victimWay]) victimWay = wayIdxT'(w);
      end
    end
  end

endmodule

// ==== source/setAssocCache.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module setAssocCache (
  input  logic             clk,
  input  logic             rst,
  input  busPkg::cpuReqT   cpuReq,
  output busPkg::cpuRespT  cpuResp,
  output busPkg::memReqT   memReq,
  input  busPkg::memRespT  memResp
);
  import cachePkg::*;
  import busPkg::*;

  addrFieldsT             fields;
  wayIdxT                 selWay;
  wayIdxT                 victimWay;
  logic [`CACHE_WAYS-1:0] hitVec;
  logic [`CACHE_WAYS-1:0] validVec;
  tagT                    selTag;
  logic                   selDirty;
  logic                   install;
  logic                   markDirty;
  logic                   dirtyIn;
  logic                   touch;
  wordIdxT                word;
  logic                   wrEn;
  byteEnT                 byteEn;
  wordT                   wrData;
  wordT                   rdData;

  cacheControl control0 (.*);

  tagStore tags0 (.*);

  lruTracker lru0 (.clk, .rst, .set(fields.set), .validVec, .touch,
                   .touchWay(selWay), .victimWay);

  dataStore data0 (.clk, .set(fields.set), .way(selWay), .word, .wrEn,
                   .byteEn, .wrData, .rdData);

endmodule

// ==== source/tagStore.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module tagStore (
  input  logic                   clk,
  input  logic                   rst,
  input  cachePkg::addrFieldsT   fields,
  input  cachePkg::wayIdxT       selWay,
  input  logic                   install,
  input  logic                   markDirty,
  input  logic                   dirtyIn,
  output logic [`CACHE_WAYS-1:0] hitVec,
  output logic [`CACHE_WAYS-1:0] validVec,
  output cachePkg::tagT          selTag,
  output logic                   selDirty
);
  import cachePkg::*;

  tagT                                    tags [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid;
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty;

  // compare all ways at once
  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      validVec[w] = valid[w][fields.set];
      hitVec[w]   = valid[w][fields.set] && (tags[w][fields.set] == fields.tag);
    end
  end

  assign selTag   = tags[selWay][fields.set];   // victim tag for write-back address
  assign selDirty = dirty[selWay][fields.set];

  always_ff @(posedge clk) begin
    if (install) begin
      tags[selWay][fields.set] <= fields.tag;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (install) begin
        valid[selWay][fields.set] <= 1'b1;
        dirty[selWay][fields.set] <= dirtyIn;
      end else if (markDirty) begin
        dirty[selWay][fields.set] <= 1'b1;   // write hit
      end
    end
  end

endmodule

// ==== tests/cacheTb.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module cacheTb;
  import busPkg::*;

  localparam int TIMEOUT   = 200;
  localparam int MEM_WORDS = 4096;

  // address layout is tag, set, word, byte offset from msb down
  localparam int WORD_LSB = `BYTE_W;
  localparam int SET_LSB  = WORD_LSB + `WORD_W;
  localparam int TAG_LSB  = SET_LSB + `SET_W;

  logic               clk;
  logic               rst;
  cpuReqT             cpuReq;
  cpuRespT            cpuResp;
  memReqT             memReq;
  memRespT            memResp;
  int                 readBursts;
  int                 writeBursts;
  logic [`ADDR_W-1:0] lastWriteAddr;

  int   checks;
  int   errors;
  wordT shadow [MEM_WORDS];   // expected memory image
  wordT respData;
  logic respMiss;
  int   respLatency;

  setAssocCache dut0 (.clk, .rst, .cpuReq, .cpuResp, .memReq, .memResp);

  memoryModel mem0 (.clk, .rst, .memReq, .memResp, .readBursts, .writeBursts,
                    .lastWriteAddr);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [`ADDR_W-1:0] makeAddr(input int tag, input int set, input int word);
    return (tag << TAG_LSB) | (set << SET_LSB) | (word << WORD_LSB);
  endfunction

  function automatic int memIndex(input logic [`ADDR_W-1:0] addr);
    return int'(addr[13:2]);
  endfunction

  function automatic wordT initialWord(input int idx);
    return wordT'(idx) * 32'h0001_0003 ^ 32'h3c5a_0000;
  endfunction

  task automatic shadowWrite(input logic [`ADDR_W-1:0] addr, input wordT data,
                             input byteEnT byteEn);
    int idx;
    idx = memIndex(addr);
    for (int b = 0; b < `DATA_W / 8; b++) begin
      if (byteEn[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // drives one request and holds it until ok
  task automatic access(input cpuOpE op, input logic [`ADDR_W-1:0] addr,
                        input wordT wdata, input byteEnT byteEn);
    int   cycles;
    logic done;
    cycles        = 0;
    done          = 1'b0;
    respMiss      = 1'b0;
    respData      = '0;
    cpuReq.valid  = 1'b1;
    cpuReq.op     = op;
    cpuReq.addr   = addr;
    cpuReq.wdata  = wdata;
    cpuReq.byteEn = byteEn;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (cpuResp.miss) respMiss = 1'b1;
      if (cpuResp.ok) begin
        done     = 1'b1;
        respData = cpuResp.rdata;
      end
    end
    respLatency = cycles;
    if (!done) begin
      errors++;
      $display("no ok from the cache within %0d cycles for address %h", TIMEOUT, addr);
    end
    @(posedge clk);
    #2;
    cpuReq.valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idleAfterReset();
    repeat (10) begin
      @(negedge clk);
      checkFlag("cpuResp.ok", cpuResp.ok, 1'b0);
      checkFlag("cpuResp.miss", cpuResp.miss, 1'b0);
      checkFlag("memReq.valid", memReq.valid, 1'b0);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic readMissThenHit();
    logic [`ADDR_W-1:0] addr;
    int                 reads;
    addr  = makeAddr(1, 1, 2);
    reads = readBursts;
    access(CPU_READ, addr, '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b1);
    checkWord("cpuResp.rdata", respData, shadow[memIndex(addr)]);
    checkCount("read bursts", readBursts - reads, 1);
    addr = makeAddr(1, 1, 3);   // same line
    access(CPU_READ, addr, '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b0);
    checkCount("hit latency", respLatency, 1);
    checkWord("cpuResp.rdata", respData, shadow[memIndex(addr)]);
    checkCount("read bursts", readBursts - reads, 1);
  endtask

  task automatic writeHitMerge();
    logic [`ADDR_W-1:0] addr;
    int                 reads;
    int                 writes;
    addr   = makeAddr(1, 1, 0);
    reads  = readBursts;
    writes = writeBursts;
    access(CPU_WRITE, addr, 32'hdead_beef, 4'b0101);
    shadowWrite(addr, 32'hdead_beef, 4'b0101);
    checkFlag("cpuResp.miss", respMiss, 1'b0);
    access(CPU_READ, addr, '0, '0);
    checkWord("cpuResp.rdata", respData, shadow[memIndex(addr)]);
    checkCount("read bursts", readBursts - reads, 0);
    checkCount("write bursts", writeBursts - writes, 0);
  endtask

  task automatic writeMissMerge();
    logic [`ADDR_W-1:0] addr;
    int                 reads;
    addr  = makeAddr(3, 2, 1);
    reads = readBursts;
    access(CPU_WRITE, addr, 32'h1234_5678, 4'b1100);
    shadowWrite(addr, 32'h1234_5678, 4'b1100);
    checkFlag("cpuResp.miss", respMiss, 1'b1);
    checkCount("read bursts", readBursts - reads, 1);
    access(CPU_READ, addr, '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b0);
    checkWord("cpuResp.rdata", respData, shadow[memIndex(addr)]);
  endtask

  // tags 10 to 13 fill set 5 and touching A=10 makes E=14 evict B=11
  task automatic lruEviction();
    for (int t = 10; t < 14; t++) begin
      access(CPU_READ, makeAddr(t, 5, 0), '0, '0);
      checkFlag("cpuResp.miss", respMiss, 1'b1);
    end
    access(CPU_READ, makeAddr(10, 5, 0), '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b0);
    access(CPU_READ, makeAddr(14, 5, 0), '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b1);
    access(CPU_READ, makeAddr(10, 5, 1), '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b0);
    access(CPU_READ, makeAddr(11, 5, 2), '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b1);
    checkWord("cpuResp.rdata", respData, shadow[memIndex(makeAddr(11, 5, 2))]);
  endtask

  task automatic writebackOnEvict();
    logic [`ADDR_W-1:0] line;
    int                 writes;
    line = makeAddr(20, 7, 0);
    access(CPU_WRITE, line, 32'hcafe_f00d, 4'b1111);
    shadowWrite(line, 32'hcafe_f00d, 4'b1111);
    access(CPU_WRITE, makeAddr(20, 7, 2), 32'h0bad_c0de, 4'b0011);
    shadowWrite(makeAddr(20, 7, 2), 32'h0bad_c0de, 4'b0011);
    writes = writeBursts;
    for (int t = 21; t < 25; t++) begin
      access(CPU_READ, makeAddr(t, 7, 0), '0, '0);
    end
    checkCount("write bursts", writeBursts - writes, 1);
    checkWord("lastWriteAddr", lastWriteAddr, line);
    for (int w = 0; w < `LINE_WORDS; w++) begin
      checkWord("memory word", mem0.mem[memIndex(line) + w], shadow[memIndex(line) + w]);
    end
    access(CPU_READ, makeAddr(20, 7, 2), '0, '0);
    checkFlag("cpuResp.miss", respMiss, 1'b1);
    checkWord("cpuResp.rdata", respData, shadow[memIndex(makeAddr(20, 7, 2))]);
    checkCount("write bursts", writeBursts - writes, 1);
  endtask

  initial begin
    clk    = 1'b0;
    rst    = 1'b1;
    cpuReq = '0;
    checks = 0;
    errors = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = initialWord(i);
    end
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    idleAfterReset();
    readMissThenHit();
    writeHitMerge();
    writeMissMerge();
    lruEviction();
    writebackOnEvict();
    checkCount("assertion failures", dut0.control0.checks0.failCount, 0);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tests/cache_assertions.sv ====
`timescale 1ns/10ps

module cacheAssertions (
  input logic            clk,
  input logic            rst,
  input busPkg::cpuRespT cpuResp,
  input busPkg::memReqT  memReq,
  input busPkg::memRespT memResp
);

  int failCount = 0;   // failed properties so far

  // ok never overlaps an open burst
  okOutsideBurst: assert property (@(posedge clk) disable iff (rst)
    !(cpuResp.ok && memReq.valid))
    else begin
      $error("cpu ok raised while a memory burst is open");
      failCount++;
    end

  addrStable: assert property (@(posedge clk) disable iff (rst)
    memReq.valid && $past(memReq.valid) |-> $stable(memReq.addr))
    else begin
      $error("memory address changed inside a burst");
      failCount++;
    end

  lastWithData: assert property (@(posedge clk) disable iff (rst)
    memResp.last |-> memResp.dataOk)
    else begin
      $error("last seen without dataOk");
      failCount++;
    end

endmodule

bind cacheControl cacheAssertions checks0 (.clk, .rst, .cpuResp, .memReq, .memResp);

// ==== tests/memoryModel.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module memoryModel (
  input  logic               clk,
  input  logic               rst,
  input  busPkg::memReqT     memReq,
  output busPkg::memRespT    memResp,
  output int                 readBursts,
  output int                 writeBursts,
  output logic [`ADDR_W-1:0] lastWriteAddr
);
  import busPkg::*;

  localparam int DEPTH = 4096;

  wordT mem [DEPTH];
  int   seed;

  // value depends on every bit of the word address
  function automatic wordT initialWord(input int idx);
    return wordT'(idx) * 32'h0001_0003 ^ 32'h3c5a_0000;
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic randomGap();
    int n;
    n = $unsigned($random(seed)) % 3;
    repeat (n) nextCycle();
  endtask

  task automatic serveBurst();
    int                 base;
    logic               isWrite;
    logic [`ADDR_W-1:0] addr;
    addr    = memReq.addr;
    base    = int'(addr[13:2]);
    isWrite = memReq.write;
    nextCycle();
    randomGap();
    memResp.addrOk = 1'b1;
    nextCycle();
    memResp.addrOk = 1'b0;
    for (int b = 0; b < `LINE_WORDS; b++) begin
      randomGap();
      memResp.dataOk = 1'b1;
      memResp.last   = (b == `LINE_WORDS - 1);
      memResp.rdata  = isWrite ? '0 : mem[(base + b) % DEPTH];
      @(negedge clk);
      if (isWrite) mem[(base + b) % DEPTH] = memReq.wdata;   // word b of the victim
      nextCycle();
      memResp.dataOk = 1'b0;
      memResp.last   = 1'b0;
    end
    if (isWrite) begin
      writeBursts++;
      lastWriteAddr = addr;
    end else begin
      readBursts++;
    end
  endtask

  initial begin
    seed          = 32'hb45d_96dd;
    memResp       = '0;
    readBursts    = 0;
    writeBursts   = 0;
    lastWriteAddr = '0;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = initialWord(i);
    end
    forever begin
      @(negedge clk);
      if (!rst && memReq.valid) serveBurst();
    end
  end

endmodule
